//--- Bender.yml
package:
  name: uart_axi_bridge

sources:
  - design/uart_axi_pkg.sv
  - design/uart_rx.sv
  - design/uart_tx.sv
  - design/cmd_parser.sv
  - design/axi_lite_master.sv
  - design/hex_responder.sv
  - design/uart_axi_bridge.sv
  - target: test
    files:
      - verification/uart_axi_bridge_properties.sv
      - verification/tb_uart_axi_bridge.sv

//--- all.f
design/uart_axi_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_parser.sv
design/axi_lite_master.sv
design/hex_responder.sv
design/uart_axi_bridge.sv
verification/uart_axi_bridge_properties.sv
verification/tb_uart_axi_bridge.sv

//--- design/axi_lite_master.sv
// AXI-Lite single-beat master
`timescale 1ns/10ps

module axi_lite_master (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   wr_pend_i,
    input  uart_axi_pkg::wr_cmd_t  wr_cmd_i,
    input  logic                   rd_pend_i,
    input  uart_axi_pkg::addr_t    rd_addr_i,
    output logic                   wr_take_o,
    output logic                   rd_take_o,
    output uart_axi_pkg::axi_req_t axi_req_o,
    input  uart_axi_pkg::axi_rsp_t axi_rsp_i,
    output logic                   rd_stb_o,
    output uart_axi_pkg::data_t    rd_data_o
);
    import uart_axi_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_ADDR_DATA, W_RESP} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} rd_state_e;

    wr_state_e wr_state_q;
    rd_state_e rd_state_q;
    logic      awvalid_q;
    logic      wvalid_q;
    logic      arvalid_q;
    addr_t     awaddr_q;
    data_t     wdata_q;
    addr_t     araddr_q;

    assign wr_take_o = (wr_state_q == W_IDLE) && wr_pend_i;
    assign rd_take_o = (rd_state_q == R_IDLE) && rd_pend_i;

    always_comb begin
        axi_req_o.awvalid = awvalid_q;
        axi_req_o.awaddr  = awaddr_q;
        axi_req_o.wvalid  = wvalid_q;
        axi_req_o.wdata   = wdata_q;
        axi_req_o.arvalid = arvalid_q;
        axi_req_o.araddr  = araddr_q;
    end

    // ------------------------------------------------------------------
    // Write channel, AW and W may complete in either order
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_state_q <= W_IDLE;
            awvalid_q  <= 1'b0;
            wvalid_q   <= 1'b0;
        end else begin
            case (wr_state_q)
                W_IDLE: begin
                    if (wr_pend_i) begin
                        awaddr_q   <= wr_cmd_i.addr;
                        wdata_q    <= wr_cmd_i.data;
                        awvalid_q  <= 1'b1;
                        wvalid_q   <= 1'b1;
                        wr_state_q <= W_ADDR_DATA;
                    end
                end
                W_ADDR_DATA: begin
                    if (axi_rsp_i.awready) awvalid_q <= 1'b0;
                    if (axi_rsp_i.wready) wvalid_q <= 1'b0;
                    if ((!awvalid_q || axi_rsp_i.awready) &&
                        (!wvalid_q || axi_rsp_i.wready)) begin
                        wr_state_q <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (axi_rsp_i.bvalid) wr_state_q <= W_IDLE;
                end
                default: wr_state_q <= W_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_state_q <= R_IDLE;
            arvalid_q  <= 1'b0;
            rd_stb_o   <= 1'b0;
        end else begin
            rd_stb_o <= 1'b0;
            case (rd_state_q)
                R_IDLE: begin
                    if (rd_pend_i) begin
                        araddr_q   <= rd_addr_i;
                        arvalid_q  <= 1'b1;
                        rd_state_q <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (axi_rsp_i.arready) begin
                        arvalid_q  <= 1'b0;
                        rd_state_q <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (axi_rsp_i.rvalid) begin
                        rd_data_o  <= axi_rsp_i.rdata;
                        rd_stb_o   <= 1'b1;
                        rd_state_q <= R_IDLE;
                    end
                end
                default: rd_state_q <= R_IDLE;
            endcase
        end
    end

endmodule

//--- design/cmd_parser.sv
// ASCII command line parser
`timescale 1ns/10ps

module cmd_parser (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  rx_stb_i,
    input  uart_axi_pkg::byte_t   rx_byte_i,
    input  logic                  wr_take_i,
    input  logic                  rd_take_i,
    output logic                  wr_pend_o,
    output uart_axi_pkg::wr_cmd_t wr_cmd_o,
    output logic                  rd_pend_o,
    output uart_axi_pkg::addr_t   rd_addr_o
);
    import uart_axi_pkg::*;

    typedef enum logic [1:0] {P_IDLE, P_ADDR, P_DATA} p_state_e;

    p_state_e   state_q;
    logic       is_wr_q;
    logic [3:0] dig_cnt_q;
    data_t      shift_q;
    addr_t      addr_q;
    logic       eol;
    logic [4:0] hex;

    // Returns {valid, nibble}, either case
    function automatic logic [4:0] hex_decode(input byte_t c);
        if (c >= "0" && c <= "9") return {1'b1, 4'(c - "0")};
        if (c >= "a" && c <= "f") return {1'b1, 4'(c - "a" + 8'd10)};
        if (c >= "A" && c <= "F") return {1'b1, 4'(c - "A" + 8'd10)};
        return 5'd0;
    endfunction

    assign hex = hex_decode(rx_byte_i);
    assign eol = (rx_byte_i == CHAR_CR) || (rx_byte_i == CHAR_LF);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= P_IDLE;
            is_wr_q   <= 1'b0;
            dig_cnt_q <= '0;
            wr_pend_o <= 1'b0;
            rd_pend_o <= 1'b0;
        end else begin
            if (wr_take_i) wr_pend_o <= 1'b0;
            if (rd_take_i) rd_pend_o <= 1'b0;
            if (rx_stb_i) begin
                case (state_q)
                    P_IDLE: begin
                        shift_q   <= '0;
                        dig_cnt_q <= '0;
                        is_wr_q   <= (rx_byte_i == "W") || (rx_byte_i == "w");
                        if (rx_byte_i inside {"W", "w", "R", "r"}) begin
                            state_q <= P_ADDR;
                        end
                    end
                    P_ADDR, P_DATA: begin
                        if (hex[4]) begin
                            // Older digits fall off the top
                            shift_q <= {shift_q[27:0], hex[3:0]};
                            if (dig_cnt_q != 4'(HEX_DIGITS)) begin
                                dig_cnt_q <= dig_cnt_q + 1'b1;
                            end
                        end else if (eol) begin
                            // Empty field or W without data abandons the line
                            if (dig_cnt_q != 4'd0 && state_q == P_DATA) begin
                                wr_cmd_o.addr <= addr_q;
                                wr_cmd_o.data <= shift_q;
                                wr_pend_o     <= 1'b1;
                            end else if (dig_cnt_q != 4'd0 && !is_wr_q) begin
                                rd_addr_o <= shift_q;
                                rd_pend_o <= 1'b1;
                            end
                            state_q <= P_IDLE;
                        end else if (rx_byte_i == " " && state_q == P_ADDR) begin
                            if (is_wr_q && dig_cnt_q != 4'd0) begin
                                addr_q    <= shift_q;
                                shift_q   <= '0;
                                dig_cnt_q <= '0;
                                state_q   <= P_DATA;
                            end else if (!is_wr_q) begin
                                state_q <= P_IDLE;
                            end
                        end
                    end
                    default: state_q <= P_IDLE;
                endcase
            end
        end
    end

endmodule

//--- design/hex_responder.sv
// Read word to ASCII hex reply
`timescale 1ns/10ps

module hex_responder (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                rd_stb_i,
    input  uart_axi_pkg::data_t rd_data_i,
    input  logic                tx_busy_i,
    output logic                tx_stb_o,
    output uart_axi_pkg::byte_t tx_byte_o
);
    import uart_axi_pkg::*;

    logic       active_q;
    logic       inflight_q;
    logic [3:0] cnt_q;
    data_t      word_q;

    function automatic byte_t nib2hex(input logic [3:0] n);
        return (n < 4'd10) ? byte_t'("0" + n) : byte_t'("a" + n - 8'd10);
    endfunction

    // Digits MSB first out of the top nibble, LF last
    assign tx_stb_o  = active_q && !inflight_q && !tx_busy_i;
    assign tx_byte_o = (cnt_q == 4'(HEX_DIGITS)) ? CHAR_LF : nib2hex(word_q[31:28]);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            active_q   <= 1'b0;
            inflight_q <= 1'b0;
            cnt_q      <= '0;
        end else if (!active_q) begin
            // A read finishing mid-reply gets no reply of its own
            if (rd_stb_i) begin
                word_q   <= rd_data_i;
                cnt_q    <= '0;
                active_q <= 1'b1;
            end
        end else if (tx_stb_o) begin
            inflight_q <= 1'b1;
        end else if (inflight_q && !tx_busy_i) begin
            // Frame done, step to the next character
            inflight_q <= 1'b0;
            word_q     <= {word_q[27:0], 4'h0};
            if (cnt_q == 4'(HEX_DIGITS)) begin
                active_q <= 1'b0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

//--- design/uart_axi_bridge.sv
// UART to AXI-Lite bridge top
`timescale 1ns/10ps

module uart_axi_bridge #(
    parameter int CLK_HZ    = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   rx_i,
    output logic                   tx_o,
    output uart_axi_pkg::axi_req_t axi_req_o,
    input  uart_axi_pkg::axi_rsp_t axi_rsp_i
);
    import uart_axi_pkg::*;

    logic    rx_stb;
    byte_t   rx_byte;
    logic    wr_pend;
    wr_cmd_t wr_cmd;
    logic    wr_take;
    logic    rd_pend;
    addr_t   rd_addr;
    logic    rd_take;
    logic    rd_stb;
    data_t   rd_data;
    logic    tx_stb;
    byte_t   tx_byte;
    logic    tx_busy;

    // ------------------------------------------------------------------
    // Receive path and command decode
    // ------------------------------------------------------------------
    uart_rx #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) u_rx (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .rx_i   (rx_i),
        .stb_o  (rx_stb),
        .data_o (rx_byte)
    );

    cmd_parser u_parser (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rx_stb_i  (rx_stb),
        .rx_byte_i (rx_byte),
        .wr_take_i (wr_take),
        .rd_take_i (rd_take),
        .wr_pend_o (wr_pend),
        .wr_cmd_o  (wr_cmd),
        .rd_pend_o (rd_pend),
        .rd_addr_o (rd_addr)
    );

    axi_lite_master u_master (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_pend_i (wr_pend),
        .wr_cmd_i  (wr_cmd),
        .rd_pend_i (rd_pend),
        .rd_addr_i (rd_addr),
        .wr_take_o (wr_take),
        .rd_take_o (rd_take),
        .axi_req_o (axi_req_o),
        .axi_rsp_i (axi_rsp_i),
        .rd_stb_o  (rd_stb),
        .rd_data_o (rd_data)
    );

    // ------------------------------------------------------------------
    // Reply path
    // ------------------------------------------------------------------
    hex_responder u_resp (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rd_stb_i  (rd_stb),
        .rd_data_i (rd_data),
        .tx_busy_i (tx_busy),
        .tx_stb_o  (tx_stb),
        .tx_byte_o (tx_byte)
    );

    uart_tx #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) u_tx (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .stb_i  (tx_stb),
        .data_i (tx_byte),
        .tx_o   (tx_o),
        .busy_o (tx_busy)
    );

endmodule

//--- design/uart_axi_pkg.sv
// UART to AXI-Lite bridge types
package uart_axi_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  byte_t;

    // One parsed write request
    typedef struct packed {
        addr_t addr;
        data_t data;
    } wr_cmd_t;

    // Master to slave
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        data_t wdata;
        logic  arvalid;
        addr_t araddr;
    } axi_req_t;

    // Slave to master, B and R are always accepted at once
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        logic  arready;
        logic  rvalid;
        data_t rdata;
    } axi_rsp_t;

    localparam byte_t CHAR_CR = 8'h0d;
    localparam byte_t CHAR_LF = 8'h0a;

    // Hex digits in one bus word
    localparam int HEX_DIGITS = 8;

endpackage

//--- design/uart_rx.sv
// UART receiver, 8-N-1
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLK_HZ    = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                rx_i,
    output logic                stb_o,
    output uart_axi_pkg::byte_t data_o
);
    import uart_axi_pkg::*;

    localparam int CLKS_PER_BIT = CLK_HZ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic [2:0]       bit_idx_q;
    byte_t            shift_q;
    logic             rx_d1_q;
    logic             rx_d2_q;

    // Two-flop synchroniser, idles high
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_d1_q <= 1'b1;
            rx_d2_q <= 1'b1;
        end else begin
            rx_d1_q <= rx_i;
            rx_d2_q <= rx_d1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= RX_IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            stb_o     <= 1'b0;
        end else begin
            stb_o <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    clk_cnt_q <= '0;
                    bit_idx_q <= '0;
                    if (!rx_d2_q) begin
                        state_q <= RX_START;
                    end
                end
                // Confirm start bit at its middle, else treat as a glitch
                RX_START: begin
                    if (clk_cnt_q == HALF_BIT) begin
                        clk_cnt_q <= '0;
                        state_q   <= rx_d2_q ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt_q == FULL_BIT) begin
                        clk_cnt_q <= '0;
                        shift_q   <= {rx_d2_q, shift_q[7:1]};
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                // Framing errors are dropped silently
                RX_STOP: begin
                    if (clk_cnt_q == FULL_BIT) begin
                        stb_o   <= rx_d2_q;
                        data_o  <= shift_q;
                        state_q <= RX_IDLE;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- design/uart_tx.sv
// UART transmitter, 8-N-1
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLK_HZ    = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                stb_i,
    input  uart_axi_pkg::byte_t data_i,
    output logic                tx_o,
    output logic                busy_o
);
    localparam int CLKS_PER_BIT = CLK_HZ / BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] clk_cnt_q;
    logic [3:0]       bit_cnt_q;
    logic [9:0]       frame_q;

    // Line follows the low end of the frame, all ones when idle
    assign tx_o   = frame_q[0];
    assign busy_o = (bit_cnt_q != 4'd0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            frame_q   <= '1;
            bit_cnt_q <= '0;
            clk_cnt_q <= '0;
        end else if (!busy_o) begin
            if (stb_i) begin
                // Stop, data LSB first, start
                frame_q   <= {1'b1, data_i, 1'b0};
                bit_cnt_q <= 4'd10;
                clk_cnt_q <= '0;
            end
        end else if (clk_cnt_q == FULL_BIT) begin
            frame_q   <= {1'b1, frame_q[9:1]};
            bit_cnt_q <= bit_cnt_q - 1'b1;
            clk_cnt_q <= '0;
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

endmodule

//--- verification/bridge_trace.txt
# op address data flag; W writes data, R reads and data is the expected reply
# flag 0 upper case with CR, 1 lower letter and mixed hex with LF, 2 long fields; J sends the rest raw
W 00001000 12345678 0
R 00001000 12345678 0
R 00002000 ffffdfff 0
W 0000abcc cafef00d 1
R 0000abcc cafef00d 1
J hello
J R 0000abcc
J W00000020
J r
R 00000020 ffffffdf 1
W 80000004 a5a55a5a 2
R 80000004 a5a55a5a 2
R 12345678 edcba987 1
W 00000010 deadbeef 0
R 00000010 deadbeef 1
W 00000010 0badc0de 1
R 00000010 0badc0de 2
W fffffffc 00000001 2
R fffffffc 00000001 0
J wxyz

//--- verification/tb_uart_axi_bridge.sv
// UART to AXI-Lite bridge testbench
`timescale 1ns/10ps

module tb_uart_axi_bridge;
    import uart_axi_pkg::*;

    localparam int CLK_HZ       = 50_000_000;
    localparam int BAUD_RATE    = 3_125_000;
    localparam int CLKS_PER_BIT = CLK_HZ / BAUD_RATE;
    localparam int CLK_PERIOD   = 20;
    localparam int OP_MARGIN_NS = 40_000;

    logic     clk_i = 1'b0;
    logic     rst_i = 1'b1;
    logic     rx    = 1'b1;
    logic     tx;
    axi_req_t axi_req;
    axi_rsp_t axi_rsp = '0;

    // Trace contents, one entry per operation
    byte_t   op_q[$];
    string   text_q[$];
    addr_t   addr_q[$];
    data_t   data_q[$];
    // Transfers still expected from the DUT
    wr_cmd_t exp_wr_q[$];
    addr_t   exp_ar_q[$];
    data_t   exp_rd_q[$];
    string   wr_name_q[$];
    string   rd_name_q[$];
    byte_t   reply_q[$];

    data_t       mem [addr_t];
    logic [31:0] lfsr_q = 32'h843c;
    logic [1:0]  aw_dly, w_dly, ar_dly;
    logic        aw_got, w_got;
    addr_t       aw_addr;
    data_t       w_data;
    int          value_errs, other_errs;
    int          writes_sent, writes_done, reads_sent, replies_done;
    longint      wd_limit_ns = 0;

    uart_axi_bridge #(.CLK_HZ(CLK_HZ), .BAUD_RATE(BAUD_RATE)) dut0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rx_i      (rx),
        .tx_o      (tx),
        .axi_req_o (axi_req),
        .axi_rsp_i (axi_rsp)
    );

    bind uart_axi_bridge uart_axi_bridge_properties props0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .tx_i      (tx_o),
        .axi_req_i (axi_req_o),
        .axi_rsp_i (axi_rsp_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Galois LFSR, one step per bit taken
    function automatic logic lfsr_bit();
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        return lfsr_q[0];
    endfunction

    function automatic logic [1:0] rand_delay();
        logic [1:0] d;
        d[0] = lfsr_bit();
        d[1] = lfsr_bit();
        return d;
    endfunction

    // Untouched words read back as the inverted address
    function automatic data_t mem_word(input addr_t a);
        return mem.exists(a) ? mem[a] : ~a;
    endfunction

    // Style 0 upper case, 1 mixed case, 2 mixed with extra leading digits
    function automatic string hex_field(input logic [31:0] v, input int style);
        string d;
        string s;
        byte_t c;
        d = $sformatf("%08h", v);
        s = (style == 2) ? "9Ac" : "";
        for (int i = 0; i < HEX_DIGITS; i++) begin
            c = d[i];
            if (c >= "a" && (style == 0 || i % 2 == 1)) c = c - 8'd32;
            s = $sformatf("%s%c", s, c);
        end
        return s;
    endfunction

    function automatic string build_cmd(input byte_t op, input addr_t a, input data_t d,
                                        input int style);
        string s;
        s = $sformatf("%c%s", (style == 1) ? op + 8'd32 : op, hex_field(a, style));
        if (op == "W") s = $sformatf("%s %s", s, hex_field(d, style));
        return $sformatf("%s%c", s, (style == 0) ? CHAR_CR : CHAR_LF);
    endfunction

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx <= frame[i];
            repeat (CLKS_PER_BIT) @(posedge clk_i);
        end
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            send_byte(s[i]);
        end
    endtask

    task automatic check_write(input string name, input wr_cmd_t exp, input wr_cmd_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_read(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic record_write(input addr_t a, input data_t d);
        if (exp_wr_q.size() == 0) begin
            $display("Unexpected AXI write to %h with data %h", a, d);
            other_errs++;
        end else begin
            check_write(wr_name_q.pop_front(), exp_wr_q.pop_front(), wr_cmd_t'({a, d}));
            writes_done++;
        end
        mem[a] = d;
    endtask

    task automatic record_read(input addr_t a);
        if (exp_ar_q.size() == 0) begin
            $display("Unexpected AXI read from %h", a);
            other_errs++;
        end else begin
            check_addr(rd_name_q[0], exp_ar_q.pop_front(), a);
        end
    endtask

    task automatic finish_reply();
        data_t got;
        byte_t c;
        got = '0;
        if (exp_rd_q.size() == 0) begin
            $display("Unexpected UART reply of %0d characters", reply_q.size());
            other_errs++;
        end else if (reply_q.size() != HEX_DIGITS + 1) begin
            $display("UART reply has %0d characters instead of 9", reply_q.size());
            other_errs++;
            void'(exp_rd_q.pop_front());
            void'(rd_name_q.pop_front());
            replies_done++;
        end else begin
            for (int i = 0; i < HEX_DIGITS; i++) begin
                c = reply_q[i];
                if (c >= "0" && c <= "9") begin
                    got = {got[27:0], 4'(c - "0")};
                end else if (c >= "a" && c <= "f") begin
                    got = {got[27:0], 4'(c - "a" + 10)};
                end else begin
                    $display("Reply character %h is not a lowercase hex digit", c);
                    other_errs++;
                end
            end
            check_read(rd_name_q.pop_front(), exp_rd_q.pop_front(), got);
            replies_done++;
        end
        reply_q.delete();
    endtask

    // ------------------------------------------------------------------
    // AXI-Lite memory model with random ready delays
    // ------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_i) begin
            axi_rsp <= '0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            aw_dly  <= rand_delay();
            w_dly   <= rand_delay();
            ar_dly  <= rand_delay();
        end else begin
            axi_rsp.bvalid <= 1'b0;
            axi_rsp.rvalid <= 1'b0;
            if (axi_req.awvalid && axi_rsp.awready) begin
                axi_rsp.awready <= 1'b0;
                aw_got          <= 1'b1;
                aw_addr         <= axi_req.awaddr;
                aw_dly          <= rand_delay();
            end else if (axi_req.awvalid && !aw_got) begin
                if (aw_dly == 2'd0) axi_rsp.awready <= 1'b1;
                else aw_dly <= aw_dly - 1'b1;
            end
            if (axi_req.wvalid && axi_rsp.wready) begin
                axi_rsp.wready <= 1'b0;
                w_got          <= 1'b1;
                w_data         <= axi_req.wdata;
                w_dly          <= rand_delay();
            end else if (axi_req.wvalid && !w_got) begin
                if (w_dly == 2'd0) axi_rsp.wready <= 1'b1;
                else w_dly <= w_dly - 1'b1;
            end
            // Both halves in, answer with B
            if (aw_got && w_got) begin
                axi_rsp.bvalid <= 1'b1;
                aw_got         <= 1'b0;
                w_got          <= 1'b0;
                record_write(aw_addr, w_data);
            end
            if (axi_req.arvalid && axi_rsp.arready) begin
                axi_rsp.arready <= 1'b0;
                axi_rsp.rvalid  <= 1'b1;
                axi_rsp.rdata   <= mem_word(axi_req.araddr);
                ar_dly          <= rand_delay();
                record_read(axi_req.araddr);
            end else if (axi_req.arvalid) begin
                if (ar_dly == 2'd0) axi_rsp.arready <= 1'b1;
                else ar_dly <= ar_dly - 1'b1;
            end
        end
    end

    // UART decoder, samples tx at mid-bit
    always begin : uart_decoder
        byte_t ch;
        @(negedge tx);
        repeat (CLKS_PER_BIT / 2) @(posedge clk_i);
        if (tx) begin
            $display("Start bit on the serial output did not hold");
            other_errs++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(posedge clk_i);
            ch[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(posedge clk_i);
        if (!tx) begin
            $display("Stop bit missing on the serial output");
            other_errs++;
        end
        reply_q.push_back(ch);
        if (ch == CHAR_LF) finish_reply();
    end

    initial begin : watchdog
        wait (wd_limit_ns != 0);
        #(wd_limit_ns);
        $display("Timeout after %0d ns, the trace did not finish", wd_limit_ns);
        $display("=== FAIL ===");
        $finish;
    end

    // ------------------------------------------------------------------
    // Trace load and stimulus
    // ------------------------------------------------------------------
    initial begin : main
        int    fd;
        int    style;
        int    chars;
        string line;
        string name;
        byte_t op;
        addr_t a;
        data_t d;
        chars = 0;
        fd = $fopen("verification/bridge_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#" || line[0] == CHAR_LF) continue;
                if (line[0] == "J") begin
                    // Raw junk text, sent with its own LF
                    line = line.substr(2, line.len() - 1);
                    while (line.len() > 0 && (line[line.len() - 1] == CHAR_LF ||
                                              line[line.len() - 1] == CHAR_CR)) begin
                        line = line.substr(0, line.len() - 2);
                    end
                    op_q.push_back("J");
                    text_q.push_back($sformatf("%s%c", line, CHAR_LF));
                    addr_q.push_back('0);
                    data_q.push_back('0);
                end else if ($sscanf(line, "%c %h %h %d", op, a, d, style) == 4) begin
                    op_q.push_back(op);
                    text_q.push_back(build_cmd(op, a, d, style));
                    addr_q.push_back(a);
                    data_q.push_back(d);
                end else begin
                    $display("Malformed trace line: %s", line);
                    other_errs++;
                end
            end
            $fclose(fd);
        end

        foreach (text_q[i]) chars += text_q[i].len();
        wd_limit_ns = longint'(chars) * 10 * CLKS_PER_BIT * CLK_PERIOD
                    + longint'(text_q.size() + 4) * OP_MARGIN_NS;

        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;

        foreach (op_q[i]) begin
            name = $sformatf("op %0d %c %h", i, op_q[i], addr_q[i]);
            case (op_q[i])
                "W": begin
                    exp_wr_q.push_back(wr_cmd_t'({addr_q[i], data_q[i]}));
                    wr_name_q.push_back(name);
                    writes_sent++;
                end
                "R": begin
                    exp_ar_q.push_back(addr_q[i]);
                    exp_rd_q.push_back(data_q[i]);
                    rd_name_q.push_back(name);
                    reads_sent++;
                end
                default: ;
            endcase
            send_text(text_q[i]);
            wait (writes_done == writes_sent && replies_done == reads_sent);
            @(posedge clk_i);
        end

        // Room for a stray transfer after a trailing junk line
        repeat (20 * CLKS_PER_BIT) @(posedge clk_i);
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verification/uart_axi_bridge_properties.sv
// AXI-Lite handshake and serial idle checks
`timescale 1ns/10ps

module uart_axi_bridge_properties (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   tx_i,
    input uart_axi_pkg::axi_req_t axi_req_i,
    input uart_axi_pkg::axi_rsp_t axi_rsp_i
);
    logic wr_open_q;

    // Open from the AW handshake until the B response
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_open_q <= 1'b0;
        end else if (axi_req_i.awvalid && axi_rsp_i.awready) begin
            wr_open_q <= 1'b1;
        end else if (axi_rsp_i.bvalid) begin
            wr_open_q <= 1'b0;
        end
    end

    aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        axi_req_i.awvalid && !axi_rsp_i.awready |=>
        axi_req_i.awvalid && $stable(axi_req_i.awaddr))
        else $error("AW valid dropped or address changed before ready");

    w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        axi_req_i.wvalid && !axi_rsp_i.wready |=>
        axi_req_i.wvalid && $stable(axi_req_i.wdata))
        else $error("W valid dropped or data changed before ready");

    ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        axi_req_i.arvalid && !axi_rsp_i.arready |=>
        axi_req_i.arvalid && $stable(axi_req_i.araddr))
        else $error("AR valid dropped or address changed before ready");

    tx_idle_in_reset: assert property (@(posedge clk_i) rst_i |=> tx_i)
        else $error("Serial output not idle during reset");

    one_write: assert property (@(posedge clk_i) disable iff (rst_i)
        wr_open_q |-> !axi_req_i.awvalid)
        else $error("Second write issued before the first one completed");

endmodule
